//--- source/sample_pkg.sv
`default_nettype none

package sample_pkg;

   // Internal sample and DAC widths
   localparam int SAMPLE_W = 24;
   localparam int DAC_W    = 16;

   // Bits dropped by the rounder
   localparam int FRAC_W = SAMPLE_W - DAC_W;

   // 18x18 multiplier operands
   localparam int CORR_W = 18;
   localparam int PROD_W = 2 * CORR_W;

   typedef logic signed [SAMPLE_W-1:0] sample_t;

   typedef logic signed [DAC_W-1:0] dac_t;

   // One complex sample, I in the upper half
   typedef struct packed {
      sample_t i;
      sample_t q;
   } iq_t;

endpackage

`default_nettype wire

//--- source/setting_pkg.sv
`default_nettype none

package setting_pkg;

   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;

   // Write strobe with address and data, no acknowledge
   typedef struct packed {
      logic                  stb;
      logic [SET_ADDR_W-1:0] addr;
      logic [SET_DATA_W-1:0] data;
   } set_bus_t;

   // Register offsets from BASE
   localparam int OFS_DCO_I = 0;
   localparam int OFS_DCO_Q = 1;
   localparam int OFS_MAG   = 2;
   localparam int OFS_PHASE = 3;
   localparam int OFS_MUX   = 4;

   typedef logic signed [sample_pkg::CORR_W-1:0] corr_t;

   typedef struct packed {
      logic [3:0] dac_b_sel;
      logic [3:0] dac_a_sel;
   } mux_ctrl_t;

   // Any other code routes zero
   localparam logic [3:0] SEL_I = 4'd0;
   localparam logic [3:0] SEL_Q = 4'd1;

endpackage

`default_nettype wire

//--- source/setting_reg.sv
`default_nettype none

module setting_reg #(
   parameter type          payload_t = logic [31:0],
   parameter logic [7:0]   MY_ADDR   = 8'd0
) (
   input  wire                    clk,
   input  wire                    i_rst,
   input  wire setting_pkg::set_bus_t i_set,
   output payload_t               o_value
);

   logic hit;

   assign hit = i_set.stb && (i_set.addr == MY_ADDR);

   // Payload takes the low bits of the data word
   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_value <= '0;
      end else if (hit) begin
         o_value <= payload_t'(i_set.data[$bits(payload_t)-1:0]);
      end
   end

endmodule

`default_nettype wire

//--- source/add_clip_reg.sv
`default_nettype none

module add_clip_reg (
   input  wire                 clk,
   input  wire                 i_rst,
   input  wire sample_pkg::sample_t i_a,
   input  wire sample_pkg::sample_t i_b,
   output sample_pkg::sample_t o_sum
);

   import sample_pkg::*;

   logic [SAMPLE_W:0] sum_full;  // One guard bit
   logic              ovf;
   sample_t           sum_sat;

   assign sum_full = {i_a[SAMPLE_W-1], i_a} + {i_b[SAMPLE_W-1], i_b};

   // Guard and sign bit disagree on overflow
   assign ovf = sum_full[SAMPLE_W] ^ sum_full[SAMPLE_W-1];

   always_comb begin
      if (!ovf) begin
         sum_sat = sample_t'(sum_full[SAMPLE_W-1:0]);
      end else if (sum_full[SAMPLE_W]) begin
         sum_sat = sample_t'({1'b1, {(SAMPLE_W-1){1'b0}}});  // Most negative
      end else begin
         sum_sat = sample_t'({1'b0, {(SAMPLE_W-1){1'b1}}});  // Most positive
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_sum <= '0;
      end else begin
         o_sum <= sum_sat;
      end
   end

endmodule

`default_nettype wire

//--- source/round_sd.sv
`default_nettype none

module round_sd (
   input  wire                 clk,
   input  wire                 i_rst,
   input  wire sample_pkg::sample_t i_in,
   output sample_pkg::dac_t    o_out
);

   import sample_pkg::*;

   logic [FRAC_W-1:0] err;       // Fraction carried from last cycle
   logic [SAMPLE_W:0] sum_full;
   logic [DAC_W:0]    sum_hi;
   dac_t              out_sat;

   // Error is unsigned, so it only ever pushes upward
   assign sum_full = {i_in[SAMPLE_W-1], i_in} + {{(SAMPLE_W+1-FRAC_W){1'b0}}, err};

   assign sum_hi = sum_full[SAMPLE_W:FRAC_W];

   always_comb begin
      if (sum_hi[DAC_W] == sum_hi[DAC_W-1]) begin
         out_sat = dac_t'(sum_hi[DAC_W-1:0]);
      end else if (sum_hi[DAC_W]) begin
         out_sat = dac_t'({1'b1, {(DAC_W-1){1'b0}}});
      end else begin
         out_sat = dac_t'({1'b0, {(DAC_W-1){1'b1}}});  // Clip to max
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_out <= '0;
         err   <= '0;
      end else begin
         o_out <= out_sat;
         err   <= sum_full[FRAC_W-1:0];
      end
   end

endmodule

`default_nettype wire

//--- source/iq_balance.sv
`default_nettype none

module iq_balance (
   input  wire                  clk,
   input  wire                  i_rst,
   input  wire sample_pkg::iq_t i_tx,
   input  wire setting_pkg::corr_t i_mag,
   input  wire setting_pkg::corr_t i_phase,
   output sample_pkg::iq_t      o_bal
);

   import sample_pkg::*;

   iq_t                      tx_d;    // Aligned with the products
   logic signed [PROD_W-1:0] prod_mag;
   logic signed [PROD_W-1:0] prod_phase;
   logic signed [CORR_W-1:0] i_top;
   sample_t                  corr_i;
   sample_t                  corr_q;
   sample_t                  bal_i;
   sample_t                  bal_q;

   // Top 18 bits of I feed both multipliers
   assign i_top = $signed(i_tx.i[SAMPLE_W-1 -: CORR_W]);

   always_ff @(posedge clk) begin
      if (i_rst) begin
         prod_mag   <= '0;
         prod_phase <= '0;
         tx_d       <= '0;
      end else begin
         prod_mag   <= i_top * i_mag;
         prod_phase <= i_top * i_phase;
         tx_d       <= i_tx;
      end
   end

   // Bits 35:16 sign-extended to sample width
   assign corr_i = sample_t'(prod_mag >>> 16);
   assign corr_q = sample_t'(prod_phase >>> 16);

   add_clip_reg u_add_i (
      .clk   (clk),
      .i_rst (i_rst),
      .i_a   (tx_d.i),
      .i_b   (corr_i),
      .o_sum (bal_i)
   );

   // Phase term leaks I into Q
   add_clip_reg u_add_q (
      .clk   (clk),
      .i_rst (i_rst),
      .i_a   (tx_d.q),
      .i_b   (corr_q),
      .o_sum (bal_q)
   );

   assign o_bal = '{i: bal_i, q: bal_q};

endmodule

`default_nettype wire

//--- source/tx_frontend.sv
`default_nettype none

module tx_frontend #(
   parameter int unsigned BASE = 0
) (
   input  wire                      clk,
   input  wire                      i_rst,
   input  wire setting_pkg::set_bus_t i_set,
   input  wire sample_pkg::iq_t     i_tx,
   output sample_pkg::dac_t         o_dac_a,
   output sample_pkg::dac_t         o_dac_b
);

   import sample_pkg::*;
   import setting_pkg::*;

   sample_t   dco_i;
   sample_t   dco_q;
   corr_t     mag_corr;
   corr_t     phase_corr;
   mux_ctrl_t mux_ctrl;
   iq_t       bal;
   sample_t   ofs_i;
   sample_t   ofs_q;
   dac_t      rnd_i;
   dac_t      rnd_q;

   // Balance, then DC offset, then rounding, then routing

   setting_reg #(.payload_t(sample_t), .MY_ADDR(8'(BASE + OFS_DCO_I))) u_sr_dco_i (
      .clk     (clk),
      .i_rst   (i_rst),
      .i_set   (i_set),
      .o_value (dco_i)
   );

   setting_reg #(.payload_t(sample_t), .MY_ADDR(8'(BASE + OFS_DCO_Q))) u_sr_dco_q (
      .clk     (clk),
      .i_rst   (i_rst),
      .i_set   (i_set),
      .o_value (dco_q)
   );

   setting_reg #(.payload_t(corr_t), .MY_ADDR(8'(BASE + OFS_MAG))) u_sr_mag (
      .clk     (clk),
      .i_rst   (i_rst),
      .i_set   (i_set),
      .o_value (mag_corr)
   );

   setting_reg #(.payload_t(corr_t), .MY_ADDR(8'(BASE + OFS_PHASE))) u_sr_phase (
      .clk     (clk),
      .i_rst   (i_rst),
      .i_set   (i_set),
      .o_value (phase_corr)
   );

   // Zero after reset routes I to both outputs
   setting_reg #(.payload_t(mux_ctrl_t), .MY_ADDR(8'(BASE + OFS_MUX))) u_sr_mux (
      .clk     (clk),
      .i_rst   (i_rst),
      .i_set   (i_set),
      .o_value (mux_ctrl)
   );

   iq_balance u_iq_balance (
      .clk     (clk),
      .i_rst   (i_rst),
      .i_tx    (i_tx),
      .i_mag   (mag_corr),
      .i_phase (phase_corr),
      .o_bal   (bal)
   );

   add_clip_reg u_dco_i (
      .clk   (clk),
      .i_rst (i_rst),
      .i_a   (bal.i),
      .i_b   (dco_i),
      .o_sum (ofs_i)
   );

   add_clip_reg u_dco_q (
      .clk   (clk),
      .i_rst (i_rst),
      .i_a   (bal.q),
      .i_b   (dco_q),
      .o_sum (ofs_q)
   );

   round_sd u_round_i (
      .clk   (clk),
      .i_rst (i_rst),
      .i_in  (ofs_i),
      .o_out (rnd_i)
   );

   round_sd u_round_q (
      .clk   (clk),
      .i_rst (i_rst),
      .i_in  (ofs_q),
      .o_out (rnd_q)
   );

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_dac_a <= '0;
         o_dac_b <= '0;
      end else begin
         case (mux_ctrl.dac_a_sel)
            SEL_I:   o_dac_a <= rnd_i;
            SEL_Q:   o_dac_a <= rnd_q;
            default: o_dac_a <= '0;
         endcase
         case (mux_ctrl.dac_b_sel)
            SEL_I:   o_dac_b <= rnd_i;
            SEL_Q:   o_dac_b <= rnd_q;
            default: o_dac_b <= '0;  // Unassigned codes mute
         endcase
      end
   end

endmodule

`default_nettype wire

//--- tests/tx_frontend_tb.sv
`default_nettype none

module tx_frontend_tb;

   import sample_pkg::*;
   import setting_pkg::*;

   localparam int unsigned BASE           = 0;
   localparam int          PHASE_CYCLES   = 400;
   localparam int          NUM_PHASES     = 6;
   localparam int          TIMEOUT_CYCLES = NUM_PHASES * PHASE_CYCLES + 600;

   localparam sample_t  SAMPLE_MAX = sample_t'(24'h7fffff);
   localparam sample_t  SAMPLE_MIN = sample_t'(24'h800000);
   localparam dac_t     DAC_MAX    = dac_t'(16'h7fff);
   localparam dac_t     DAC_MIN    = dac_t'(16'h8000);
   localparam set_bus_t IDLE       = '0;

   logic     clk;
   logic     i_rst;
   set_bus_t i_set;
   iq_t      i_tx;
   dac_t     o_dac_a;
   dac_t     o_dac_b;

   logic [31:0] rng_state;
   int          cycle_count = 0;
   string       test_name;
   logic        model_live  = 1'b0;

   // Reference model state, one variable per register stage
   sample_t           m_dco_i;
   sample_t           m_dco_q;
   corr_t             m_mag;
   corr_t             m_phase;
   mux_ctrl_t         m_mux;
   sample_t           m_corr_i;  // Product already sliced to 24 bits
   sample_t           m_corr_q;
   iq_t               m_tx_d;
   sample_t           m_bal_i;
   sample_t           m_bal_q;
   sample_t           m_ofs_i;
   sample_t           m_ofs_q;
   dac_t              m_rnd_i;
   dac_t              m_rnd_q;
   logic [FRAC_W-1:0] m_err_i;
   logic [FRAC_W-1:0] m_err_q;
   dac_t              m_dac_a;
   dac_t              m_dac_b;

   tx_frontend #(.BASE(BASE)) u_tx_frontend (
      .clk     (clk),
      .i_rst   (i_rst),
      .i_set   (i_set),
      .i_tx    (i_tx),
      .o_dac_a (o_dac_a),
      .o_dac_b (o_dac_b)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] rand32();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   function automatic iq_t rand_iq();
      return '{i: sample_t'(rand32()), q: sample_t'(rand32())};
   endfunction

   // Full scale half the time
   function automatic sample_t pick_sample();
      logic [31:0] r;
      r = rand32();
      case (r[1:0])
         2'd0:    return SAMPLE_MAX;
         2'd1:    return SAMPLE_MIN;
         default: return sample_t'(r >> 8);
      endcase
   endfunction

   function automatic corr_t pick_corr();
      logic [31:0] r;
      r = rand32();
      case (r[1:0])
         2'd0:    return corr_t'(18'h1ffff);
         2'd1:    return corr_t'(18'h20000);
         2'd2:    return corr_t'(18'h3ffff);  // Minus one
         default: return corr_t'(r >> 14);
      endcase
   endfunction

   function automatic logic [7:0] reg_addr(input int ofs);
      return 8'(BASE + ofs);
   endfunction

   function automatic set_bus_t write_word(input logic [7:0] addr, input logic [31:0] data);
      return '{stb: 1'b1, addr: addr, data: data};
   endfunction

   function automatic sample_t clip_add(input sample_t a, input sample_t b);
      longint s;
      s = longint'(a) + longint'(b);
      if (s > longint'(SAMPLE_MAX)) begin
         return SAMPLE_MAX;
      end else if (s < longint'(SAMPLE_MIN)) begin
         return SAMPLE_MIN;
      end
      return sample_t'(s);
   endfunction

   // Top 18 bits of the sample times the factor, keep bits 35:16
   function automatic sample_t product_term(input sample_t x, input corr_t k);
      longint p;
      p = longint'($signed(x[SAMPLE_W-1 -: CORR_W])) * longint'(k);
      return sample_t'(p >>> 16);
   endfunction

   function automatic dac_t route(input logic [3:0] sel, input dac_t ri, input dac_t rq);
      if (sel == SEL_I) begin
         return ri;
      end else if (sel == SEL_Q) begin
         return rq;
      end
      return '0;
   endfunction

   task automatic round_step(input sample_t x, input logic [FRAC_W-1:0] err_in,
                             output dac_t y, output logic [FRAC_W-1:0] err_out);
      longint s;
      longint hi;
      s       = longint'(x) + longint'(err_in);
      hi      = s >>> FRAC_W;
      err_out = s[FRAC_W-1:0];
      if (hi > longint'(DAC_MAX)) begin
         y = DAC_MAX;
      end else if (hi < longint'(DAC_MIN)) begin
         y = DAC_MIN;
      end else begin
         y = dac_t'(hi);
      end
   endtask

   // Next state from old state, settings updated last
   task automatic model_step();
      dac_t              n_rnd_i;
      dac_t              n_rnd_q;
      logic [FRAC_W-1:0] n_err_i;
      logic [FRAC_W-1:0] n_err_q;
      if (i_rst) begin
         {m_dco_i, m_dco_q, m_mag, m_phase, m_mux} = '0;
         {m_corr_i, m_corr_q, m_tx_d, m_bal_i, m_bal_q, m_ofs_i, m_ofs_q} = '0;
         {m_rnd_i, m_rnd_q, m_err_i, m_err_q, m_dac_a, m_dac_b} = '0;
         model_live = 1'b1;
      end else begin
         m_dac_a = route(m_mux.dac_a_sel, m_rnd_i, m_rnd_q);
         m_dac_b = route(m_mux.dac_b_sel, m_rnd_i, m_rnd_q);
         round_step(m_ofs_i, m_err_i, n_rnd_i, n_err_i);
         round_step(m_ofs_q, m_err_q, n_rnd_q, n_err_q);
         {m_rnd_i, m_rnd_q, m_err_i, m_err_q} = {n_rnd_i, n_rnd_q, n_err_i, n_err_q};
         m_ofs_i  = clip_add(m_bal_i, m_dco_i);
         m_ofs_q  = clip_add(m_bal_q, m_dco_q);
         m_bal_i  = clip_add(m_tx_d.i, m_corr_i);
         m_bal_q  = clip_add(m_tx_d.q, m_corr_q);
         m_corr_i = product_term(i_tx.i, m_mag);
         m_corr_q = product_term(i_tx.i, m_phase);
         m_tx_d   = i_tx;
         if (i_set.stb) begin
            if (i_set.addr == reg_addr(OFS_DCO_I)) m_dco_i = sample_t'(i_set.data[23:0]);
            if (i_set.addr == reg_addr(OFS_DCO_Q)) m_dco_q = sample_t'(i_set.data[23:0]);
            if (i_set.addr == reg_addr(OFS_MAG))   m_mag   = corr_t'(i_set.data[17:0]);
            if (i_set.addr == reg_addr(OFS_PHASE)) m_phase = corr_t'(i_set.data[17:0]);
            if (i_set.addr == reg_addr(OFS_MUX))   m_mux   = mux_ctrl_t'(i_set.data[7:0]);
         end
      end
   endtask

   task automatic check_dac(input string name, input dac_t expected, input dac_t actual);
      if (actual !== expected) begin
         $display("Error: %s expected %0d actual %0d", name, expected, actual);
         $display("Done: errors found");
         $fatal(1, "Output mismatch on %s", name);
      end
   endtask

   task automatic drive_cycle(input set_bus_t s, input iq_t x);
      @(posedge clk);
      i_set <= s;
      i_tx  <= x;
   endtask

   always @(posedge clk) begin
      model_step();
   end

   always @(negedge clk) begin
      if (model_live && !i_rst) begin
         check_dac({test_name, " dac_a"}, m_dac_a, o_dac_a);
         check_dac({test_name, " dac_b"}, m_dac_b, o_dac_b);
      end
   end

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Done: errors found");
         $fatal(1, "Timeout");
      end
   end

   task automatic default_traffic();
      test_name = "reset_defaults";
      repeat (PHASE_CYCLES) drive_cycle(IDLE, rand_iq());
   endtask

   task automatic sweep_routing();
      int          c;
      int          k;
      logic [31:0] r;
      test_name = "routing";
      k = 0;
      for (c = 0; c < PHASE_CYCLES; c++) begin
         r = rand32();
         if (c % 10 != 0) begin
            drive_cycle(IDLE, rand_iq());
         end else if (k < 16) begin
            // Sweep every code on both halves first
            drive_cycle(write_word(reg_addr(OFS_MUX), {r[31:8], 4'(15 - k), 4'(k)}), rand_iq());
            k++;
         end else begin
            drive_cycle(write_word(reg_addr(OFS_MUX), r), rand_iq());
         end
      end
   endtask

   task automatic stress_dc_offset();
      int          c;
      logic [31:0] r;
      test_name = "dc_offset";
      drive_cycle(write_word(reg_addr(OFS_MUX), 32'h10), rand_iq());  // A gets I, B gets Q
      for (c = 1; c < PHASE_CYCLES; c++) begin
         r = rand32();
         if (c % 20 == 1) begin
            drive_cycle(write_word(reg_addr(OFS_DCO_I), {r[7:0], pick_sample()}), rand_iq());
         end else if (c % 20 == 2) begin
            drive_cycle(write_word(reg_addr(OFS_DCO_Q), {r[7:0], pick_sample()}), rand_iq());
         end else begin
            drive_cycle(IDLE, '{i: pick_sample(), q: pick_sample()});
         end
      end
   endtask

   task automatic vary_balance();
      int          c;
      logic [31:0] r;
      test_name = "iq_balance";
      drive_cycle(write_word(reg_addr(OFS_DCO_I), 32'h0), rand_iq());
      drive_cycle(write_word(reg_addr(OFS_DCO_Q), 32'h0), rand_iq());
      for (c = 2; c < PHASE_CYCLES; c++) begin
         r = rand32();
         if (c % 16 == 2) begin
            drive_cycle(write_word(reg_addr(OFS_MAG), {r[31:18], pick_corr()}), rand_iq());
         end else if (c % 16 == 3) begin
            drive_cycle(write_word(reg_addr(OFS_PHASE), {r[31:18], pick_corr()}), rand_iq());
         end else begin
            drive_cycle(IDLE, '{i: pick_sample(), q: sample_t'(r)});
         end
      end
   endtask

   task automatic hold_round_inputs();
      int  c;
      iq_t hold;
      test_name = "round_feedback";
      drive_cycle(write_word(reg_addr(OFS_MAG), 32'h0), rand_iq());
      drive_cycle(write_word(reg_addr(OFS_PHASE), 32'h0), rand_iq());
      hold = '0;
      for (c = 2; c < PHASE_CYCLES; c++) begin
         if (c % 50 == 2) begin
            hold = rand_iq();
            hold.i[0] = 1'b1;  // Keep a nonzero fraction
            hold.q[0] = 1'b1;
         end
         drive_cycle(IDLE, hold);
      end
   endtask

   task automatic probe_address_decode();
      int          c;
      logic [31:0] r;
      test_name = "address_decode";
      drive_cycle(write_word(reg_addr(OFS_MAG), rand32()), rand_iq());
      drive_cycle(write_word(reg_addr(OFS_PHASE), rand32()), rand_iq());
      drive_cycle(write_word(reg_addr(OFS_DCO_I), rand32()), rand_iq());
      drive_cycle(write_word(reg_addr(OFS_DCO_Q), rand32()), rand_iq());
      drive_cycle(write_word(reg_addr(OFS_MUX), 32'h01), rand_iq());  // Swapped routing
      for (c = 5; c < PHASE_CYCLES; c++) begin
         r = rand32();
         if (r[0]) begin
            drive_cycle(write_word(8'(5 + (r >> 8) % 251), rand32()), rand_iq());
         end else begin
            // Strobe low aimed at the live registers
            drive_cycle('{stb: 1'b0, addr: reg_addr(r[15:8] % 5), data: rand32()}, rand_iq());
         end
      end
   endtask

   initial begin
      rng_state = 32'h968a;
      i_rst     = 1'b1;
      i_set     = '0;
      i_tx      = '0;
      test_name = "reset";
      repeat (2) @(posedge clk);
      i_rst <= 1'b0;
      default_traffic();
      sweep_routing();
      stress_dc_offset();
      vary_balance();
      hold_round_inputs();
      probe_address_decode();
      repeat (8) drive_cycle(IDLE, '0);  // Drain the pipeline
      $display("Done: no errors");
      $finish;
   end

endmodule

`default_nettype wire

//--- project.f
source/sample_pkg.sv
source/setting_pkg.sv
source/setting_reg.sv
source/add_clip_reg.sv
source/round_sd.sv
source/iq_balance.sv
source/tx_frontend.sv
tests/tx_frontend_tb.sv

//--- Makefile
# Verilator build for the transmit front end testbench
# Override any variable on the command line, e.g. make run BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= tx_frontend_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing
RUN_ARGS  ?=

SOURCES := $(wildcard source/*.sv) $(wildcard tests/*.sv)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulation is the pass or fail result
run: compile
	./$(BINARY) $(RUN_ARGS)

clean:
	rm -rf $(BUILD_DIR)
